/* common/gf2_elim_pkg.sv */
// row width constants, token and output structs, token opcode, output kind and state enums
package gf2_elim_pkg;

  // one elimination cell per coefficient column
  localparam int COLS = 4;

  // augmented (right-hand side) bits carried with every row
  localparam int AUG_W = 4;

  localparam int ROW_W = COLS + AUG_W;

  // bit i of coef belongs to cell i
  typedef struct packed {
    logic [COLS-1:0]  coef;
    logic [AUG_W-1:0] aug;
  } row_t;

  // what a token means to the cells
  typedef enum logic [1:0] {
    OP_ROW   = 2'd0,
    OP_PIVOT = 2'd1,
    OP_DRAIN = 2'd2
  } tok_op_t;

  // one pipeline slot whose last flag marks the final token of a phase
  typedef struct packed {
    logic    valid;
    tok_op_t op;
    logic    last;
    row_t    row;
  } tok_t;

  typedef enum logic {
    OUT_RESIDUE = 1'b0,
    OUT_PIVOT   = 1'b1
  } out_kind_t;

  typedef struct packed {
    out_kind_t kind;
    row_t      row;
  } out_row_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_STREAM = 2'd1,
    ST_DRAIN  = 2'd2,
    ST_WAIT   = 2'd3
  } phase_state_t;

endpackage

/* elimination/elim_array.sv */
// chain of elimination cells and the tail stage that emits rows, fail and done
`timescale 1ns/10ps

module elim_array (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   advance,
  input  gf2_elim_pkg::tok_t     in_tok,
  output gf2_elim_pkg::out_row_t out_row,
  output logic                   out_valid,
  output logic                   advance_block,
  output logic                   done,
  output logic                   fail
);

  gf2_elim_pkg::tok_t link [gf2_elim_pkg::COLS+1];
  gf2_elim_pkg::tok_t tail_tok;

  logic tail_out;

  assign link[0] = in_tok;

  for (genvar i = 0; i < gf2_elim_pkg::COLS; i++) begin : gen_cells
    elim_cell #(
      .COL(i)
    ) elim_cell_inst (
      .clk    (clk),
      .reset  (reset),
      .clear  (clear),
      .advance(advance),
      .in_tok (link[i]),
      .out_tok(link[i+1])
    );
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      tail_tok.valid <= 1'b0;
      fail           <= 1'b0;
    end else if (advance) begin
      tail_tok <= link[gf2_elim_pkg::COLS];
      // a drain token that found no pivot anywhere means a missing column
      if (link[gf2_elim_pkg::COLS].valid &&
          (link[gf2_elim_pkg::COLS].op == gf2_elim_pkg::OP_DRAIN)) begin
        fail <= 1'b1;
      end
    end
  end

  // drain tokens are dropped here and never need a credit
  assign tail_out      = tail_tok.valid && (tail_tok.op != gf2_elim_pkg::OP_DRAIN);
  assign advance_block = tail_out;
  assign out_valid     = tail_out && advance;
  assign done          = tail_tok.valid && tail_tok.last && advance;

  assign out_row.kind = (tail_tok.op == gf2_elim_pkg::OP_PIVOT) ? gf2_elim_pkg::OUT_PIVOT
                                                                : gf2_elim_pkg::OUT_RESIDUE;
  assign out_row.row  = tail_tok.row;

endmodule

/* elimination/elim_cell.sv */
// systolic GF(2) elimination cell with one pivot slot for its column
`timescale 1ns/10ps

module elim_cell #(
  parameter int COL = 0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               clear,
  input  logic               advance,
  input  gf2_elim_pkg::tok_t in_tok,
  output gf2_elim_pkg::tok_t out_tok
);

  gf2_elim_pkg::row_t pivot;
  gf2_elim_pkg::tok_t tok_next;

  logic                           full;
  logic                           full_next;
  logic                           take;
  logic [gf2_elim_pkg::ROW_W-1:0] reduced;

  // GF(2) row addition
  assign reduced = in_tok.row ^ pivot;

  always_comb begin
    tok_next  = in_tok;
    full_next = full;
    take      = 1'b0;
    if (in_tok.valid) begin
      case (in_tok.op)
        gf2_elim_pkg::OP_ROW: begin
          if (in_tok.row.coef[COL]) begin
            if (!full) begin
              // first row with this column set becomes the pivot
              take           = 1'b1;
              full_next      = 1'b1;
              tok_next.valid = 1'b0;
            end else begin
              tok_next.row = reduced;
            end
          end
        end
        gf2_elim_pkg::OP_DRAIN: begin
          if (full) begin
            tok_next.op  = gf2_elim_pkg::OP_PIVOT;
            tok_next.row = pivot;
            full_next    = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      full          <= 1'b0;
      out_tok.valid <= 1'b0;
    end else if (advance) begin
      full    <= full_next;
      out_tok <= tok_next;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && take) begin
      pivot <= in_tok.row;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the GF(2) elimination testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module elim_tb \
  --Mdir obj_dir -o elim_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/elim_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

/* source/elim_top.sv */
// top level joining row memory, phase controller and elimination array of the GF(2) engine
`timescale 1ns/10ps

module elim_top #(
  parameter int MAX_ROWS    = 16,
  parameter int OUT_CREDITS = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          load_en,
  input  logic [$clog2(MAX_ROWS)-1:0]   load_addr,
  input  gf2_elim_pkg::row_t            load_row,
  input  logic                          start,
  input  logic [$clog2(MAX_ROWS+1)-1:0] row_count,
  output gf2_elim_pkg::out_row_t        out_row,
  output logic                          out_valid,
  input  logic                          credit_return,
  output logic                          busy,
  output logic                          done,
  output logic                          fail
);

  gf2_elim_pkg::tok_t mem_tok;
  gf2_elim_pkg::tok_t inj_tok;
  gf2_elim_pkg::tok_t in_tok;

  logic                        rd_en;
  logic [$clog2(MAX_ROWS)-1:0] rd_addr;
  logic                        advance;
  logic                        advance_block;
  logic                        clear;

  // memory rows and drain tokens never occupy the head slot together
  assign in_tok = mem_tok.valid ? mem_tok : inj_tok;

  row_memory #(
    .MAX_ROWS(MAX_ROWS)
  ) row_memory_inst (
    .clk      (clk),
    .reset    (reset),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_row (load_row),
    .advance  (advance),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_tok   (mem_tok)
  );

  phase_control #(
    .MAX_ROWS   (MAX_ROWS),
    .OUT_CREDITS(OUT_CREDITS)
  ) phase_control_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .row_count    (row_count),
    .advance_block(advance_block),
    .credit_return(credit_return),
    .done         (done),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .inj_tok      (inj_tok),
    .advance      (advance),
    .busy         (busy),
    .clear        (clear)
  );

  elim_array elim_array_inst (
    .clk          (clk),
    .reset        (reset),
    .clear        (clear),
    .advance      (advance),
    .in_tok       (in_tok),
    .out_row      (out_row),
    .out_valid    (out_valid),
    .advance_block(advance_block),
    .done         (done),
    .fail         (fail)
  );

endmodule

/* source/phase_control.sv */
// phase FSM, read sequencing, drain token injection and output credit counter
`timescale 1ns/10ps

module phase_control #(
  parameter int MAX_ROWS    = 16,
  parameter int OUT_CREDITS = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic [$clog2(MAX_ROWS+1)-1:0] row_count,
  input  logic                          advance_block,
  input  logic                          credit_return,
  input  logic                          done,
  output logic                          rd_en,
  output logic [$clog2(MAX_ROWS)-1:0]   rd_addr,
  output gf2_elim_pkg::tok_t            inj_tok,
  output logic                          advance,
  output logic                          busy,
  output logic                          clear
);

  localparam int AW  = $clog2(MAX_ROWS);
  localparam int CW  = $clog2(MAX_ROWS + 1);
  localparam int CRW = $clog2(OUT_CREDITS + 1);
  localparam int DW  = (gf2_elim_pkg::COLS > 1) ? $clog2(gf2_elim_pkg::COLS) : 1;

  gf2_elim_pkg::phase_state_t state;
  gf2_elim_pkg::tok_t         drain_tok;

  logic [CW-1:0]  count_q;
  logic [CW-1:0]  issued;
  logic [DW-1:0]  drain_cnt;
  logic [CRW-1:0] credits;
  logic           start_ok;
  logic           stream_rd;
  logic           consume;
  logic           drain_last;

  assign start_ok   = start && (state == gf2_elim_pkg::ST_IDLE);
  assign clear      = start_ok;
  assign busy       = (state != gf2_elim_pkg::ST_IDLE);
  assign stream_rd  = (state == gf2_elim_pkg::ST_STREAM);
  assign drain_last = (drain_cnt == DW'(gf2_elim_pkg::COLS - 1));

  // pipeline moves unless a row waits at the tail with no credit left
  assign advance = (credits != '0) || !advance_block;
  assign consume = advance_block && advance;

  // row 0 is read in the start cycle itself
  assign rd_en   = advance && (start_ok || stream_rd);
  assign rd_addr = stream_rd ? issued[AW-1:0] : '0;

  always_comb begin
    drain_tok.valid = (state == gf2_elim_pkg::ST_DRAIN);
    drain_tok.op    = gf2_elim_pkg::OP_DRAIN;
    drain_tok.last  = drain_last;
    drain_tok.row   = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= gf2_elim_pkg::ST_IDLE;
    end else begin
      case (state)
        gf2_elim_pkg::ST_IDLE: begin
          if (start) begin
            state <= (row_count <= CW'(1)) ? gf2_elim_pkg::ST_DRAIN : gf2_elim_pkg::ST_STREAM;
          end
        end
        gf2_elim_pkg::ST_STREAM: begin
          if (advance && (issued + CW'(1) == count_q)) begin
            state <= gf2_elim_pkg::ST_DRAIN;
          end
        end
        gf2_elim_pkg::ST_DRAIN: begin
          if (advance && drain_last) begin
            state <= gf2_elim_pkg::ST_WAIT;
          end
        end
        gf2_elim_pkg::ST_WAIT: begin
          // last token has left the tail
          if (done) begin
            state <= gf2_elim_pkg::ST_IDLE;
          end
        end
        default: state <= gf2_elim_pkg::ST_IDLE;
      endcase
    end
  end

  // read and drain sequencing
  always_ff @(posedge clk) begin
    if (start_ok) begin
      count_q <= row_count;
      issued  <= CW'(1);
    end else if (stream_rd && advance) begin
      issued <= issued + CW'(1);
    end
    if (state != gf2_elim_pkg::ST_DRAIN) begin
      drain_cnt <= '0;
    end else if (advance) begin
      drain_cnt <= drain_cnt + DW'(1);
    end
  end

  // drain slot sits beside the memory read register
  always_ff @(posedge clk) begin
    if (reset) begin
      inj_tok.valid <= 1'b0;
    end else if (advance) begin
      inj_tok <= drain_tok;
    end
  end

  // credit counter is refilled at start and capped at OUT_CREDITS
  always_ff @(posedge clk) begin
    if (reset || start_ok) begin
      credits <= CRW'(OUT_CREDITS);
    end else if (consume && !credit_return) begin
      credits <= credits - CRW'(1);
    end else if (!consume && credit_return && (credits < CRW'(OUT_CREDITS))) begin
      credits <= credits + CRW'(1);
    end
  end

endmodule

/* source/row_memory.sv */
// host-written row storage with a registered token read port that holds while stalled
`timescale 1ns/10ps

module row_memory #(
  parameter int MAX_ROWS = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        load_en,
  input  logic [$clog2(MAX_ROWS)-1:0] load_addr,
  input  gf2_elim_pkg::row_t          load_row,
  input  logic                        advance,
  input  logic                        rd_en,
  input  logic [$clog2(MAX_ROWS)-1:0] rd_addr,
  output gf2_elim_pkg::tok_t          rd_tok
);

  gf2_elim_pkg::row_t rows [MAX_ROWS];

  always_ff @(posedge clk) begin
    if (load_en) begin
      rows[load_addr] <= load_row;
    end
  end

  // head slot of the pipeline whose payload changes only on a read
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_tok.valid <= 1'b0;
    end else if (advance) begin
      rd_tok.valid <= rd_en;
    end
    if (rd_en) begin
      rd_tok.op   <= gf2_elim_pkg::OP_ROW;
      rd_tok.last <= 1'b0;
      rd_tok.row  <= rows[rd_addr];
    end
  end

endmodule

/* sources.f */
+incdir+tests
common/gf2_elim_pkg.sv
source/row_memory.sv
source/phase_control.sv
elimination/elim_cell.sv
elimination/elim_array.sv
source/elim_top.sv
tests/elim_tb.sv

/* tests/elim_model.svh */
// reference model for one elimination phase: expected residue rows, pivot rows and fail flag
`ifndef ELIM_MODEL_SVH
`define ELIM_MODEL_SVH

// reads matrix_q, refills expected_q, returns the expected fail flag
function automatic logic model_phase();
  gf2_elim_pkg::row_t            pivots [gf2_elim_pkg::COLS];
  gf2_elim_pkg::row_t            r;
  gf2_elim_pkg::out_row_t        o;
  logic [gf2_elim_pkg::COLS-1:0] have;
  logic                          kept;
  expected_q.delete();
  have = '0;
  foreach (matrix_q[n]) begin
    r    = matrix_q[n];
    kept = 1'b0;
    // a row meets the columns in ascending order
    for (int i = 0; i < gf2_elim_pkg::COLS; i++) begin
      if (!kept && r.coef[i]) begin
        if (!have[i]) begin
          pivots[i] = r;
          have[i]   = 1'b1;
          kept      = 1'b1;
        end else begin
          r = r ^ pivots[i];
        end
      end
    end
    if (!kept) begin
      o.kind = gf2_elim_pkg::OUT_RESIDUE;
      o.row  = r;
      expected_q.push_back(o);
    end
  end
  // drain releases stored pivots from column 0 upward
  for (int i = 0; i < gf2_elim_pkg::COLS; i++) begin
    if (have[i]) begin
      o.kind = gf2_elim_pkg::OUT_PIVOT;
      o.row  = pivots[i];
      expected_q.push_back(o);
    end
  end
  return !(&have);
endfunction

`endif

/* tests/elim_tb.sv */
// testbench with clock, reset, phase stimulus, credit-holding sink, checks and timeout
`timescale 1ns/10ps

module elim_tb;

  localparam int MAX_ROWS       = 16;
  localparam int OUT_CREDITS    = 4;
  localparam int COLS           = gf2_elim_pkg::COLS;
  localparam int AUG_W          = gf2_elim_pkg::AUG_W;
  localparam int ROW_W          = gf2_elim_pkg::ROW_W;
  localparam int AW             = $clog2(MAX_ROWS);
  localparam int CW             = $clog2(MAX_ROWS + 1);
  localparam int PHASE_COUNT    = 14;
  // load, start overhead, and every token stalled by a full credit hold
  localparam int PHASE_WORST    = MAX_ROWS + 8 + (MAX_ROWS + 2 * COLS + 4) * 5;
  localparam int TIMEOUT_CYCLES = 5 * PHASE_COUNT * PHASE_WORST;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   load_en;
  logic [AW-1:0]          load_addr;
  gf2_elim_pkg::row_t     load_row;
  logic                   start;
  logic [CW-1:0]          row_count;
  gf2_elim_pkg::out_row_t out_row;
  logic                   out_valid;
  logic                   credit_return = 1'b0;
  logic                   busy;
  logic                   done;
  logic                   fail;

  gf2_elim_pkg::row_t     matrix_q[$];
  gf2_elim_pkg::out_row_t expected_q[$];
  gf2_elim_pkg::out_row_t got_q[$];

  string test_name = "reset";
  bit    random_holds = 1'b0;
  int    outstanding;
  int    hold_cnt;
  int    done_count;
  logic  fail_at_done;
  int    cycle_count = 0;

  `include "elim_model.svh"

  elim_top #(
    .MAX_ROWS   (MAX_ROWS),
    .OUT_CREDITS(OUT_CREDITS)
  ) elim_top_inst (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_row     (load_row),
    .start        (start),
    .row_count    (row_count),
    .out_row      (out_row),
    .out_valid    (out_valid),
    .credit_return(credit_return),
    .busy         (busy),
    .done         (done),
    .fail         (fail)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_int(input string name, input string what, input int exp, input int got);
    assert (exp == got)
      else stop_with_failure($sformatf("FAIL %s: %s expected %0d, actual %0d",
                                       name, what, exp, got));
  endtask

  task automatic check_row(input string name, input int idx,
                           input gf2_elim_pkg::out_row_t exp, input gf2_elim_pkg::out_row_t got);
    assert (exp == got)
      else stop_with_failure($sformatf("FAIL %s: output %0d expected %h, actual %h",
                                       name, idx, exp, got));
  endtask

  // a row may leave only while the engine still holds a credit
  credit_guard: assert property (@(posedge clk) disable iff (reset)
                                 out_valid |-> (outstanding < OUT_CREDITS))
    else stop_with_failure("an output row was sent while the engine held no credit");

  // sink that collects rows, counts done pulses and returns credits after optional holds
  always @(posedge clk) begin
    int next_out;
    if (reset) begin
      outstanding   <= 0;
      hold_cnt      <= 0;
      done_count    <= 0;
      fail_at_done  <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      if (start) begin
        got_q.delete();
        done_count <= 0;
      end
      if (out_valid) begin
        got_q.push_back(out_row);
        if (out_row.kind == gf2_elim_pkg::OUT_RESIDUE) begin
          assert (out_row.row.coef == '0)
            else stop_with_failure($sformatf("FAIL %s: residue coef expected 0, actual %h",
                                             test_name, out_row.row.coef));
        end
      end
      if (done) begin
        done_count   <= done_count + 1;
        fail_at_done <= fail;
      end
      next_out = outstanding + (out_valid ? 1 : 0) - (credit_return ? 1 : 0);
      assert (next_out <= OUT_CREDITS)
        else stop_with_failure("more rows were sent than the credit limit allows");
      outstanding <= next_out;
      if ((next_out > 0) && (hold_cnt == 0)) begin
        credit_return <= 1'b1;
        hold_cnt      <= random_holds ? int'($urandom % 4) : 0;
      end else begin
        credit_return <= 1'b0;
        if (hold_cnt > 0) begin
          hold_cnt <= hold_cnt - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_failure("the run did not finish within the cycle limit");
    end
  end

  task automatic make_full_rank(input int n);
    do begin
      matrix_q.delete();
      repeat (n) matrix_q.push_back(ROW_W'($urandom));
    end while (model_phase());
  endtask

  task automatic make_identity();
    gf2_elim_pkg::row_t r;
    matrix_q.delete();
    for (int i = 0; i < COLS; i++) begin
      r.coef = COLS'(1) << i;
      r.aug  = AUG_W'($urandom);
      matrix_q.push_back(r);
    end
  endtask

  // column 3 is never set and row 0 shows up twice
  task automatic make_deficient();
    int coefs [5] = '{1, 2, 4, 3, 6};
    gf2_elim_pkg::row_t r;
    matrix_q.delete();
    foreach (coefs[i]) begin
      r.coef = COLS'(coefs[i]);
      r.aug  = AUG_W'($urandom);
      matrix_q.push_back(r);
    end
    matrix_q.push_back(matrix_q[0]);
  endtask

  task automatic run_phase(input string name, input bit holds);
    logic exp_fail;
    test_name    = name;
    random_holds = holds;
    foreach (matrix_q[n]) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= AW'(n);
      load_row  <= matrix_q[n];
    end
    @(posedge clk);
    load_en  <= 1'b0;
    exp_fail = model_phase();
    @(posedge clk);
    start     <= 1'b1;
    row_count <= CW'(matrix_q.size());
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    check_int(name, "busy after start", 1, int'(busy));
    check_int(name, "fail after start", 0, int'(fail));
    while (!done) @(posedge clk);
    @(posedge clk);
    check_int(name, "busy after done", 0, int'(busy));
    // let the sink hand back every credit before the next phase
    while ((outstanding != 0) || credit_return) @(posedge clk);
    repeat (2) @(posedge clk);
    check_int(name, "done pulses", 1, done_count);
    check_int(name, "fail at done", int'(exp_fail), int'(fail_at_done));
    check_int(name, "fail held", int'(exp_fail), int'(fail));
    check_int(name, "output count", expected_q.size(), got_q.size());
    foreach (expected_q[k]) begin
      check_row(name, k, expected_q[k], got_q[k]);
    end
  endtask

  function automatic int count_pivots();
    int pivots = 0;
    foreach (got_q[k]) begin
      if (got_q[k].kind == gf2_elim_pkg::OUT_PIVOT) begin
        pivots++;
      end
    end
    return pivots;
  endfunction

  initial begin
    gf2_elim_pkg::out_row_t exp_row;
    void'($urandom(87));
    reset     <= 1'b1;
    load_en   <= 1'b0;
    load_addr <= '0;
    load_row  <= '0;
    start     <= 1'b0;
    row_count <= '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_int("reset", "out_valid", 0, int'(out_valid));
    check_int("reset", "done", 0, int'(done));
    check_int("reset", "busy", 0, int'(busy));
    check_int("reset", "fail", 0, int'(fail));

    // identity rows come straight back as pivots
    make_identity();
    run_phase("identity", 1'b0);
    check_int("identity", "pivot count", COLS, count_pivots());
    foreach (matrix_q[k]) begin
      exp_row.kind = gf2_elim_pkg::OUT_PIVOT;
      exp_row.row  = matrix_q[k];
      check_row("identity", k, exp_row, got_q[k]);
    end

    repeat (6) begin
      make_full_rank(8 + int'($urandom % 9));
      run_phase("full_rank", 1'b0);
    end

    make_deficient();
    run_phase("rank_deficient", 1'b0);
    check_int("rank_deficient", "pivot count", COLS - 1, count_pivots());

    repeat (4) begin
      make_full_rank(MAX_ROWS);
      run_phase("credit_hold", 1'b1);
    end

    // a failing phase followed by a clean one
    make_deficient();
    run_phase("recover_fail", 1'b1);
    make_full_rank(12);
    run_phase("recover_clean", 1'b1);
    check_int("recover_clean", "pivot count", COLS, count_pivots());

    $display("Simulation passed");
    $finish;
  end

endmodule
